/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_phivers_edge
FILELIST  ?= phivers_edge.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
RUN_FLAGS ?= +verilator+error+limit+100

SOURCES := $(shell grep -v '^+' $(FILELIST)) rtl/phivers_edge_params.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS)

clean:
	rm -rf $(BUILD_DIR)

/* phivers_edge.f */
+incdir+rtl
rtl/phivers_edge_pkg.sv
rtl/task_injector.sv
rtl/peripheral_port_arbiter.sv
rtl/phivers_edge.sv
sim/phivers_edge_assertions.sv
sim/tb_phivers_edge.sv

/* rtl/peripheral_port_arbiter.sv */
`timescale 1ns/100ps

module peripheral_port_arbiter
    import phivers_edge_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  logic      release_peripheral_i,

    input  noc_chan_t ma_chan_i,
    output logic      ma_credit_o,

    input  noc_chan_t app_chan_i,
    output logic      app_credit_o,

    output noc_chan_t noc_o,
    input  logic      noc_credit_i
);

    logic gnt_valid_q;
    logic gnt_app_q;
    logic prefer_app_q;

    logic ma_req;
    logic app_req;
    logic active;
    logic sel_app;
    logic xfer;

    always_comb begin
        ma_req  = ma_chan_i.tx;
        // app injector held back until the peripheral is released.
        app_req = app_chan_i.tx && release_peripheral_i;

        if (gnt_valid_q) begin
            // a granted packet always finishes.
            active  = 1'b1;
            sel_app = gnt_app_q;
        end
        else if (ma_req && app_req) begin
            active  = 1'b1;
            sel_app = prefer_app_q;
        end
        else begin
            active  = ma_req || app_req;
            sel_app = app_req;
        end

        noc_o        = sel_app ? app_chan_i : ma_chan_i;
        ma_credit_o  = active && !sel_app && noc_credit_i;
        app_credit_o = active && sel_app && noc_credit_i;
        xfer         = noc_o.tx && noc_credit_i;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            gnt_valid_q  <= 1'b0;
            gnt_app_q    <= 1'b0;
            prefer_app_q <= 1'b0;
        end
        else if (xfer && noc_o.eop) begin
            gnt_valid_q  <= 1'b0;
            // other side wins the next tie.
            prefer_app_q <= !sel_app;
        end
        else if (active && !gnt_valid_q) begin
            gnt_valid_q <= 1'b1;
            gnt_app_q   <= sel_app;
        end
    end

endmodule

/* rtl/phivers_edge.sv */
`timescale 1ns/100ps

module phivers_edge
    import phivers_edge_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  noc_addr_t mapper_address_i,
    input  logic      release_peripheral_i,

    input  src_word_t ma_src_i,
    output logic      ma_src_credit_o,

    input  src_word_t app_src_i,
    output logic      app_src_credit_o,

    output noc_chan_t noc_o,
    input  logic      noc_credit_i
);

    noc_chan_t ma_chan;
    noc_chan_t app_chan;
    logic      ma_chan_credit;
    logic      app_chan_credit;

    // mapping agent, header built from the mapper address.
    task_injector #(
        .INJECT_MAPPER (1'b1)
    )
    i_ma_injector (
        .clk_i            (clk_i           ),
        .rst_i            (rst_i           ),
        .mapper_address_i (mapper_address_i),
        .src_i            (ma_src_i        ),
        .src_credit_o     (ma_src_credit_o ),
        .chan_o           (ma_chan         ),
        .chan_credit_i    (ma_chan_credit  )
    );

    // application source supplies its own header.
    task_injector #(
        .INJECT_MAPPER (1'b0)
    )
    i_app_injector (
        .clk_i            (clk_i           ),
        .rst_i            (rst_i           ),
        .mapper_address_i (mapper_address_i),
        .src_i            (app_src_i       ),
        .src_credit_o     (app_src_credit_o),
        .chan_o           (app_chan        ),
        .chan_credit_i    (app_chan_credit )
    );

    peripheral_port_arbiter i_arbiter (
        .clk_i                (clk_i               ),
        .rst_i                (rst_i               ),
        .release_peripheral_i (release_peripheral_i),
        .ma_chan_i            (ma_chan             ),
        .ma_credit_o          (ma_chan_credit      ),
        .app_chan_i           (app_chan            ),
        .app_credit_o         (app_chan_credit     ),
        .noc_o                (noc_o               ),
        .noc_credit_i         (noc_credit_i        )
    );

endmodule

/* rtl/phivers_edge_params.svh */
`ifndef PHIVERS_EDGE_PARAMS_SVH
`define PHIVERS_EDGE_PARAMS_SVH

// hermes flit and source word width.
`define PHIVERS_FLIT_W 32

// noc address, x in upper byte and y in lower byte.
`define PHIVERS_ADDR_W 16

// size flits above this are clipped.
`define PHIVERS_MAX_PAYLOAD 32

// must hold PHIVERS_MAX_PAYLOAD.
`define PHIVERS_CNT_W 6

`endif

/* rtl/phivers_edge_pkg.sv */
`include "phivers_edge_params.svh"

package phivers_edge_pkg;

    typedef logic [`PHIVERS_FLIT_W-1:0] flit_t;
    typedef logic [`PHIVERS_ADDR_W-1:0] noc_addr_t;
    typedef logic [`PHIVERS_CNT_W-1:0]  payload_cnt_t;

    // word offered by a task source.
    typedef struct packed {
        logic  rx;
        flit_t data;
    } src_word_t;

    // outbound hermes channel, credit travels back separately.
    typedef struct packed {
        logic  tx;
        logic  eop;
        flit_t data;
    } noc_chan_t;

    // last flit kind loaded into the output register.
    typedef enum logic [1:0] {
        IDLE,
        HEADER,
        SIZE,
        PAYLOAD
    } inj_state_e;

endpackage

/* rtl/task_injector.sv */
`timescale 1ns/100ps
`include "phivers_edge_params.svh"

module task_injector
    import phivers_edge_pkg::*;
#(
    parameter bit INJECT_MAPPER = 1'b0
)
(
    input  logic      clk_i,
    input  logic      rst_i,

    input  noc_addr_t mapper_address_i,

    input  src_word_t src_i,
    output logic      src_credit_o,

    output noc_chan_t chan_o,
    input  logic      chan_credit_i
);

    inj_state_e   state_q;
    inj_state_e   state_d;
    payload_cnt_t cnt_q;
    payload_cnt_t cnt_d;
    payload_cnt_t size_cnt;

    logic         tx_q;
    logic         tx_d;
    logic         eop_q;
    logic         eop_d;
    flit_t        data_q;
    flit_t        data_d;

    logic         reg_free;
    logic         take;

    always_comb begin
        // register is free when empty or draining on this edge.
        reg_free = !tx_q || chan_credit_i;

        // in idle the mapper variant only inserts its header.
        take = src_i.rx && reg_free && ((state_q != IDLE) || !INJECT_MAPPER);

        if (src_i.data > flit_t'(`PHIVERS_MAX_PAYLOAD)) begin
            size_cnt = payload_cnt_t'(`PHIVERS_MAX_PAYLOAD);
        end
        else begin
            size_cnt = src_i.data[`PHIVERS_CNT_W-1:0];
        end

        state_d = state_q;
        cnt_d   = cnt_q;
        tx_d    = tx_q && !chan_credit_i;
        eop_d   = eop_q;
        data_d  = data_q;

        case (state_q)
            IDLE: begin
                if (src_i.rx && reg_free) begin
                    tx_d    = 1'b1;
                    eop_d   = 1'b0;
                    data_d  = INJECT_MAPPER ? flit_t'(mapper_address_i) : src_i.data;
                    state_d = HEADER;
                end
            end

            HEADER: begin
                if (take) begin
                    tx_d    = 1'b1;
                    eop_d   = (size_cnt == '0);
                    data_d  = flit_t'(size_cnt);
                    cnt_d   = size_cnt;
                    // empty packet ends on the size flit.
                    state_d = (size_cnt == '0) ? IDLE : SIZE;
                end
            end

            SIZE, PAYLOAD: begin
                if (take) begin
                    tx_d    = 1'b1;
                    eop_d   = (cnt_q == payload_cnt_t'(1));
                    data_d  = src_i.data;
                    cnt_d   = cnt_q - payload_cnt_t'(1);
                    state_d = (cnt_q == payload_cnt_t'(1)) ? IDLE : PAYLOAD;
                end
            end
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
            tx_q    <= 1'b0;
        end
        else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
            tx_q    <= tx_d;
        end
    end

    // flit payload, qualified by tx_q.
    always_ff @(posedge clk_i) begin
        eop_q  <= eop_d;
        data_q <= data_d;
    end

    assign src_credit_o = take;

    assign chan_o = '{tx: tx_q, eop: eop_q, data: data_q};

endmodule

/* sim/phivers_edge_assertions.sv */
`timescale 1ns/100ps

module phivers_edge_assertions
    import phivers_edge_pkg::*;
(
    input logic      clk_i,
    input logic      rst_i,
    input noc_addr_t mapper_address_i,
    input logic      release_peripheral_i,
    input src_word_t ma_src_i,
    input logic      ma_src_credit_o,
    input src_word_t app_src_i,
    input logic      app_src_credit_o,
    input noc_chan_t noc_o,
    input logic      noc_credit_i
);

    logic [7:0] pos_q;
    logic [7:0] size_q;
    logic       is_ma_q;
    logic       offered_q;
    logic       xfer;
    logic       mapper_header;
    logic       eop_expected;

    logic       idle_failed    = 1'b0;
    logic       tag_failed     = 1'b0;
    logic       eop_failed     = 1'b0;
    logic       release_failed = 1'b0;
    logic       hold_failed    = 1'b0;
    logic       any_failed;

    always_comb begin
        xfer          = noc_o.tx && noc_credit_i;
        mapper_header = (noc_o.data == flit_t'(mapper_address_i));
        // header never ends a packet, an empty packet ends on its size flit.
        if (pos_q == 8'd0) begin
            eop_expected = 1'b0;
        end
        else if (pos_q == 8'd1) begin
            eop_expected = (noc_o.data == '0);
        end
        else begin
            eop_expected = (pos_q == size_q + 8'd1);
        end
    end

    // flit position inside the packet on the port.
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pos_q     <= '0;
            offered_q <= 1'b0;
        end
        else begin
            if (ma_src_i.rx || app_src_i.rx) begin
                offered_q <= 1'b1;
            end
            if (xfer) begin
                pos_q <= noc_o.eop ? 8'd0 : pos_q + 8'd1;
                if (pos_q == 8'd0) begin
                    is_ma_q <= mapper_header;
                end
                if (pos_q == 8'd1) begin
                    size_q <= noc_o.data[7:0];
                end
            end
        end
    end

    assign any_failed = idle_failed || tag_failed || eop_failed || release_failed || hold_failed;

    idle_after_reset: assert property (@(posedge clk_i) disable iff (rst_i)
        !offered_q && !ma_src_i.rx && !app_src_i.rx
        |-> !noc_o.tx && !ma_src_credit_o && !app_src_credit_o)
    else begin
        idle_failed = 1'b1;
        $error("NoC port or a source credit went active before any word was offered");
    end

    // every payload tag follows the header, so packets cannot mix.
    payload_tag: assert property (@(posedge clk_i) disable iff (rst_i)
        xfer && pos_q >= 8'd2 |-> noc_o.data[31] == is_ma_q)
    else begin
        tag_failed = 1'b1;
        $error("Mismatch noc_o.data[31]: got %h, expected %h",
               $sampled(noc_o.data[31]), $sampled(is_ma_q));
    end

    eop_position: assert property (@(posedge clk_i) disable iff (rst_i)
        xfer |-> noc_o.eop == eop_expected)
    else begin
        eop_failed = 1'b1;
        $error("Mismatch noc_o.eop: got %h, expected %h",
               $sampled(noc_o.eop), $sampled(eop_expected));
    end

    app_after_release: assert property (@(posedge clk_i) disable iff (rst_i)
        xfer && pos_q == 8'd0 && !mapper_header |-> release_peripheral_i)
    else begin
        release_failed = 1'b1;
        $error("application header sent while the peripheral was not released");
    end

    hold_without_credit: assert property (@(posedge clk_i) disable iff (rst_i)
        noc_o.tx && !noc_credit_i |=> $stable(noc_o.data) && $stable(noc_o.eop))
    else begin
        hold_failed = 1'b1;
        $error("flit on the NoC port changed while it waited for credit");
    end

endmodule

bind phivers_edge phivers_edge_assertions i_assertions (.*);

/* sim/tb_phivers_edge.sv */
`timescale 1ns/100ps

module tb_phivers_edge
    import phivers_edge_pkg::*;
();

    localparam int        N_PACKETS   = 6;
    localparam int        MAX_WAIT    = 2000;
    localparam noc_addr_t MAPPER_ADDR = 16'h0203;
    localparam flit_t     APP_HEADER  = 32'h0000_0011;
    localparam flit_t     MA_TAG      = 32'h8000_0000;

    logic      clk_i;
    logic      rst_i;
    noc_addr_t mapper_address_i;
    logic      release_peripheral_i;
    src_word_t ma_src_i;
    logic      ma_src_credit_o;
    src_word_t app_src_i;
    logic      app_src_credit_o;
    noc_chan_t noc_o;
    logic      noc_credit_i;

    integer    seed;
    int        sizes [2][N_PACKETS];
    int        eop_count;

    phivers_edge i_phivers_edge (.*);

    always #5 clk_i = ~clk_i;

    // packets seen complete on the port.
    always @(posedge clk_i) begin
        if (rst_i) begin
            eop_count <= 0;
        end
        else if (noc_o.tx && noc_credit_i && noc_o.eop) begin
            eop_count <= eop_count + 1;
        end
    end

    // roughly one cycle in four without credit.
    always @(negedge clk_i) begin
        noc_credit_i = (($random(seed) & 3) != 0);
    end

    task automatic abort_run(input string why);
        $display("Simulation finished: FAIL");
        $fatal(1, "%s", why);
    endtask

    task automatic watch_assertions();
        forever begin
            @(negedge clk_i);
            if (i_phivers_edge.i_assertions.any_failed) begin
                abort_run("a protocol assertion on the NoC port failed");
            end
        end
    endtask

    // called on a falling edge, returns on the falling edge after acceptance.
    task automatic send_word(input bit is_app, input flit_t word);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (is_app) begin
            app_src_i = '{rx: 1'b1, data: word};
        end
        else begin
            ma_src_i = '{rx: 1'b1, data: word};
        end
        while (!taken) begin
            @(posedge clk_i);
            taken  = is_app ? app_src_credit_o : ma_src_credit_o;
            waited = waited + 1;
            if (!taken && waited > MAX_WAIT) begin
                abort_run(is_app ? "timeout waiting for the application source credit"
                                 : "timeout waiting for the mapping agent source credit");
            end
        end
        @(negedge clk_i);
    endtask

    task automatic run_source(input bit is_app);
        flit_t tag;
        tag = is_app ? '0 : MA_TAG;
        for (int p = 0; p <= N_PACKETS; p++) begin
            int n_payload;
            // last packet of each source is empty.
            n_payload = (p < N_PACKETS) ? sizes[is_app][p] : 0;
            if (is_app) begin
                send_word(1'b1, APP_HEADER);
            end
            send_word(is_app, flit_t'(n_payload));
            for (int w = 0; w < n_payload; w++) begin
                send_word(is_app, tag | flit_t'(p * 256 + w));
            end
            if (is_app) begin
                app_src_i.rx = 1'b0;
            end
            else begin
                ma_src_i.rx = 1'b0;
            end
            @(negedge clk_i);
        end
    endtask

    initial begin
        int waited;
        clk_i                = 1'b0;
        rst_i                = 1'b1;
        mapper_address_i     = MAPPER_ADDR;
        release_peripheral_i = 1'b0;
        ma_src_i             = '0;
        app_src_i            = '0;
        noc_credit_i         = 1'b0;
        seed                 = 32'hae27_426f;
        for (int s = 0; s < 2; s++) begin
            for (int p = 0; p < N_PACKETS; p++) begin
                sizes[s][p] = 1 + int'($unsigned($random(seed)) % 8);
            end
        end
        fork
            watch_assertions();
        join_none
        repeat (4) @(negedge clk_i);
        rst_i = 1'b0;
        // sources stay quiet for a few cycles after reset.
        repeat (3) @(negedge clk_i);
        fork
            run_source(1'b0);
            run_source(1'b1);
            begin
                repeat (80) @(negedge clk_i);
                release_peripheral_i = 1'b1;
            end
        join
        waited = 0;
        while (eop_count < 2 * (N_PACKETS + 1)) begin
            @(negedge clk_i);
            waited = waited + 1;
            if (waited > MAX_WAIT) begin
                abort_run("timeout waiting for the last packets on the NoC port");
            end
        end
        @(negedge clk_i);
        if (i_phivers_edge.i_assertions.any_failed) begin
            abort_run("a protocol assertion on the NoC port failed");
        end
        else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule
